// File: hdl/cpu_sm_config.svh
// CPU bus master configuration

`ifndef CPU_SM_CONFIG_SVH
`define CPU_SM_CONFIG_SVH

// Flip-flops on each asynchronous control input
// Two is enough at BCLK rates, three gives extra MTBF margin
`define CPU_SM_SYNC_STAGES 2

// Longwords moved in one bus tenure before the bus is given back
`define CPU_SM_BURST_LIMIT 4

`endif

// File: hdl/cpu_bus_pkg.sv
// CPU bus types

package cpu_bus_pkg;

    // Bus arbitration and cycle states
    typedef enum logic [2:0] {
        IDLE       = 3'd0,
        REQUEST    = 3'd1,
        OWN        = 3'd2,
        ADDR       = 3'd3,
        DATA       = 3'd4,
        HALF2_ADDR = 3'd5,
        HALF2_DATA = 3'd6,
        RELEASE    = 3'd7
    } bus_state_t;

    // Port width reported by the slave termination
    typedef logic [1:0] port_size_t;

    localparam port_size_t PORT_NONE = 2'd0;
    localparam port_size_t PORT_16   = 2'd1;
    localparam port_size_t PORT_32   = 2'd2;

    typedef struct packed {
        logic       done;
        port_size_t port_size;
        logic       sync_term;
    } bus_term_t;

    typedef struct packed {
        logic breq;
        logic bgack;
        logic pas;
        logic pds;
        logic size1;
        logic a1;
    } bus_strobe_t;

endpackage

// File: hdl/dma_ctrl_pkg.sv
// DMA control types

`include "cpu_sm_config.svh"

package dma_ctrl_pkg;

    // Synchronized view of the SCSI side request
    typedef struct packed {
        logic need_xfer;
        logic dir;
        logic flush_done;
        logic enabled;
    } xfer_req_t;

    // FIFO and address counter controls
    typedef struct packed {
        logic incfifo;
        logic decfifo;
        logic incno;
        logic f2cpuh;
        logic f2cpul;
        logic dieh;
        logic diel;
        logic stopflush;
    } fifo_ctl_t;

    // Longwords completed in the current tenure
    typedef logic [$clog2(`CPU_SM_BURST_LIMIT + 1)-1:0] xfer_count_t;

endpackage

// File: hdl/bus_term_decode.sv
// Bus termination decoder

`timescale 1ns/1ps

module bus_term_decode (
    input  logic                  BCLK,
    input  logic                  CCRESET_,
    input  logic [1:0]            dsack_,
    input  logic                  sterm_,
    input  logic                  pas,
    output cpu_bus_pkg::bus_term_t term
);

    logic [1:0]              dsack_q_;
    logic                    sterm_q_;
    logic                    seen_q;
    cpu_bus_pkg::port_size_t size_dec;
    logic                    hit;

    // STERM takes priority over DSACK when decoding the port size
    always_comb begin
        if (!sterm_q_) begin
            size_dec = cpu_bus_pkg::PORT_32;
        end else begin
            unique case (dsack_q_)
                2'b00:   size_dec = cpu_bus_pkg::PORT_32;
                2'b01:   size_dec = cpu_bus_pkg::PORT_16;
                default: size_dec = cpu_bus_pkg::PORT_NONE;
            endcase
        end
    end

    // First valid termination of this strobe only
    assign hit = (size_dec != cpu_bus_pkg::PORT_NONE) && !seen_q;

    always_ff @(posedge BCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            dsack_q_ <= 2'b11;
            sterm_q_ <= 1'b1;
            seen_q   <= 1'b0;
            term     <= '0;
        end else begin
            if (!pas) begin
                // Latch held clear while no address strobe is out
                dsack_q_ <= 2'b11;
                sterm_q_ <= 1'b1;
                seen_q   <= 1'b0;
            end else begin
                dsack_q_ <= dsack_;
                sterm_q_ <= sterm_;
                if (hit) begin
                    seen_q <= 1'b1;
                end
            end
            term.done      <= hit && pas;
            term.port_size <= size_dec;
            term.sync_term <= !sterm_q_;
        end
    end

endmodule

// File: hdl/xfer_request.sv
// Transfer request evaluator

`timescale 1ns/1ps

`include "cpu_sm_config.svh"

module xfer_request (
    input  logic                    BCLK,
    input  logic                    CCRESET_,
    input  logic                    dma_ena,
    input  logic                    dreq_,
    input  logic                    flush_fifo,
    input  logic                    dma_dir,
    input  logic                    fifo_empty,
    input  logic                    fifo_full,
    output dma_ctrl_pkg::xfer_req_t req
);

    localparam int STAGES = `CPU_SM_SYNC_STAGES;

    // Idle value of the controls with the active low DREQ released high
    localparam logic [5:0] SYNC_IDLE = 6'b010000;

    logic [5:0]             async_in;
    logic [STAGES-1:0][5:0] sync_q;
    logic                   ena_s;
    logic                   dreq_s_;
    logic                   flush_s;
    logic                   dir_s;
    logic                   empty_s;
    logic                   full_s;
    logic                   room;
    logic                   flush_cond;
    logic                   flush_seen_q;

    assign async_in = {dma_ena, dreq_, flush_fifo, dma_dir, fifo_empty, fifo_full};
    assign {ena_s, dreq_s_, flush_s, dir_s, empty_s, full_s} = sync_q[STAGES-1];

    always_ff @(posedge BCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            sync_q <= {STAGES{SYNC_IDLE}};
        end else begin
            sync_q[0] <= async_in;
            for (int i = 1; i < STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    // Memory to FIFO needs space and FIFO to memory needs data
    assign room       = dir_s ? !empty_s : !full_s;
    assign flush_cond = flush_s && dir_s && empty_s;

    always_ff @(posedge BCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            req          <= '0;
            flush_seen_q <= 1'b0;
        end else begin
            req.need_xfer  <= ena_s && !dreq_s_ && room;
            req.dir        <= dir_s;
            req.enabled    <= ena_s;
            req.flush_done <= flush_cond && !flush_seen_q;
            // Remembered until the flush request goes away
            flush_seen_q   <= flush_s && (flush_seen_q || flush_cond);
        end
    end

endmodule

// File: hdl/cpu_bus_fsm.sv
// CPU bus cycle state machine

`timescale 1ns/1ps

`include "cpu_sm_config.svh"

module cpu_bus_fsm (
    input  logic                      BCLK,
    input  logic                      CCRESET_,
    input  logic                      bgrant_,
    input  dma_ctrl_pkg::xfer_req_t   req,
    input  cpu_bus_pkg::bus_term_t    term,
    output cpu_bus_pkg::bus_strobe_t  strobe,
    output dma_ctrl_pkg::fifo_ctl_t   fifo_ctl
);

    // Cycles in OWN after a longword until the FIFO flags reach req again
    localparam int SETTLE   = `CPU_SM_SYNC_STAGES + 4;
    localparam int SETTLE_W = $clog2(SETTLE + 1);

    cpu_bus_pkg::bus_state_t   state_q;
    cpu_bus_pkg::bus_state_t   state_d;
    dma_ctrl_pkg::xfer_count_t count_q;
    dma_ctrl_pkg::xfer_count_t count_d;
    logic [SETTLE_W-1:0]       settle_q;
    logic [SETTLE_W-1:0]       settle_d;
    logic [1:0]                grant_sync_q_;
    logic                      granted;
    logic                      go;
    logic                      complete;
    cpu_bus_pkg::bus_strobe_t  strobe_d;
    dma_ctrl_pkg::fifo_ctl_t   fifo_d;

    assign granted = !grant_sync_q_[1];
    assign go      = req.need_xfer && req.enabled;

    always_comb begin
        state_d  = state_q;
        count_d  = count_q;
        settle_d = settle_q;
        complete = 1'b0;
        unique case (state_q)
            cpu_bus_pkg::IDLE: begin
                count_d = '0;
                if (go) begin
                    state_d = cpu_bus_pkg::REQUEST;
                end
            end
            cpu_bus_pkg::REQUEST: begin
                if (granted) begin
                    state_d  = cpu_bus_pkg::OWN;
                    settle_d = '0;
                end
            end
            cpu_bus_pkg::OWN: begin
                if (settle_q != '0) begin
                    settle_d = settle_q - 1'b1;
                end else if (go &&
                             count_q < dma_ctrl_pkg::xfer_count_t'(`CPU_SM_BURST_LIMIT)) begin
                    state_d = cpu_bus_pkg::ADDR;
                end else begin
                    state_d = cpu_bus_pkg::RELEASE;
                end
            end
            cpu_bus_pkg::ADDR:       state_d = cpu_bus_pkg::DATA;
            cpu_bus_pkg::DATA: begin
                if (term.done) begin
                    // A 16-bit port takes the low word in a second cycle
                    if (term.port_size == cpu_bus_pkg::PORT_16) begin
                        state_d = cpu_bus_pkg::HALF2_ADDR;
                    end else begin
                        complete = 1'b1;
                    end
                end
            end
            cpu_bus_pkg::HALF2_ADDR: state_d = cpu_bus_pkg::HALF2_DATA;
            cpu_bus_pkg::HALF2_DATA: complete = term.done;
            cpu_bus_pkg::RELEASE:    state_d = cpu_bus_pkg::IDLE;
            default:                 state_d = cpu_bus_pkg::IDLE;
        endcase
        if (complete) begin
            state_d  = cpu_bus_pkg::OWN;
            count_d  = count_q + 1'b1;
            settle_d = SETTLE_W'(SETTLE);
        end
    end

    // Output values for the coming state
    always_comb begin
        strobe_d.breq  = (state_d == cpu_bus_pkg::REQUEST);
        strobe_d.bgack = (state_d != cpu_bus_pkg::IDLE) && (state_d != cpu_bus_pkg::REQUEST);
        strobe_d.pds   = (state_d == cpu_bus_pkg::DATA) || (state_d == cpu_bus_pkg::HALF2_DATA);
        // HALF2_ADDR leaves pas low so the slave sees a new cycle
        strobe_d.pas   = strobe_d.pds || (state_d == cpu_bus_pkg::ADDR);
        strobe_d.a1    = (state_d == cpu_bus_pkg::HALF2_ADDR) ||
                         (state_d == cpu_bus_pkg::HALF2_DATA);
        strobe_d.size1 = strobe_d.a1;

        fifo_d.incno     = complete;
        fifo_d.incfifo   = complete && !req.dir;
        fifo_d.dieh      = complete && !req.dir;
        fifo_d.diel      = complete && !req.dir;
        fifo_d.decfifo   = complete && req.dir;
        fifo_d.f2cpuh    = strobe_d.pds && req.dir;
        fifo_d.f2cpul    = strobe_d.pds && req.dir;
        fifo_d.stopflush = req.flush_done;
    end

    always_ff @(posedge BCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            state_q       <= cpu_bus_pkg::IDLE;
            count_q       <= '0;
            settle_q      <= '0;
            grant_sync_q_ <= 2'b11;
            strobe        <= '0;
            fifo_ctl      <= '0;
        end else begin
            state_q       <= state_d;
            count_q       <= count_d;
            settle_q      <= settle_d;
            grant_sync_q_ <= {grant_sync_q_[0], bgrant_};
            strobe        <= strobe_d;
            fifo_ctl      <= fifo_d;
        end
    end

endmodule

// File: hdl/cpu_sm.sv
// SCSI DMA CPU bus master

`timescale 1ns/1ps

module cpu_sm (
    input  logic                     BCLK,
    input  logic                     CCRESET_,
    input  logic                     bgrant_,
    input  logic                     dma_ena,
    input  logic                     dreq_,
    input  logic                     flush_fifo,
    input  logic                     dma_dir,
    input  logic                     fifo_empty,
    input  logic                     fifo_full,
    input  logic [1:0]               dsack_,
    input  logic                     sterm_,
    output cpu_bus_pkg::bus_strobe_t strobe,
    output dma_ctrl_pkg::fifo_ctl_t  fifo_ctl
);

    dma_ctrl_pkg::xfer_req_t req;
    cpu_bus_pkg::bus_term_t  term;

    xfer_request i_xfer_request (
        .BCLK       (BCLK),
        .CCRESET_   (CCRESET_),
        .dma_ena    (dma_ena),
        .dreq_      (dreq_),
        .flush_fifo (flush_fifo),
        .dma_dir    (dma_dir),
        .fifo_empty (fifo_empty),
        .fifo_full  (fifo_full),
        .req        (req)
    );

    // Address strobe fed back to clear the termination latch
    bus_term_decode i_bus_term_decode (
        .BCLK     (BCLK),
        .CCRESET_ (CCRESET_),
        .dsack_   (dsack_),
        .sterm_   (sterm_),
        .pas      (strobe.pas),
        .term     (term)
    );

    cpu_bus_fsm i_cpu_bus_fsm (
        .BCLK     (BCLK),
        .CCRESET_ (CCRESET_),
        .bgrant_  (bgrant_),
        .req      (req),
        .term     (term),
        .strobe   (strobe),
        .fifo_ctl (fifo_ctl)
    );

endmodule

// File: test/cpu_sm_tb.sv
// CPU bus master testbench

`timescale 1ns/1ps

`include "cpu_sm_config.svh"

module cpu_sm_tb;

    localparam int TIMEOUT = 2000;
    localparam int DEPTH   = 8;
    localparam int LIMIT   = `CPU_SM_BURST_LIMIT;
    localparam int QUIET   = 12;

    logic                     BCLK;
    logic                     CCRESET_;
    logic                     bgrant_ = 1'b1;
    logic                     dma_ena;
    logic                     dreq_;
    logic                     flush_fifo;
    logic                     dma_dir;
    logic                     fifo_empty;
    logic                     fifo_full;
    logic [1:0]               dsack_ = 2'b11;
    logic                     sterm_ = 1'b1;
    cpu_bus_pkg::bus_strobe_t strobe;
    dma_ctrl_pkg::fifo_ctl_t  fifo_ctl;

    // FIFO occupancy model and slave port type
    int fifo_level = 0;
    int port_type  = 0;

    // Bus model state
    logic [31:0] rng = 32'd17;
    int          grant_wait = -1;
    int          slave_wait = -1;
    logic        breq_seen = 1'b0;
    logic        grant_seen = 1'b0;
    logic        bgack_q = 1'b0;

    // Monitor counters are cleared at the start of each test
    int   lw_count;
    int   inc_count;
    int   dec_count;
    int   pas_cycles;
    int   a1_cycles;
    int   sf_count;
    int   tenures;
    int   tenure_sum;
    int   tenure_lw;
    logic prev_pas = 1'b0;
    logic prev_bgack = 1'b0;

    int   errors = 0;
    int   checks = 0;
    int   test_num = 0;
    logic timed_out = 1'b0;

    assign fifo_empty = (fifo_level == 0);
    assign fifo_full  = (fifo_level == DEPTH);

    cpu_sm i_cpu_sm (
        .BCLK       (BCLK),
        .CCRESET_   (CCRESET_),
        .bgrant_    (bgrant_),
        .dma_ena    (dma_ena),
        .dreq_      (dreq_),
        .flush_fifo (flush_fifo),
        .dma_dir    (dma_dir),
        .fifo_empty (fifo_empty),
        .fifo_full  (fifo_full),
        .dsack_     (dsack_),
        .sterm_     (sterm_),
        .strobe     (strobe),
        .fifo_ctl   (fifo_ctl)
    );

    initial begin
        BCLK = 1'b0;
        forever #4 BCLK = ~BCLK;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic compare_count(input string name, input int expected, input int actual);
        checks++;
        assert (actual == expected) else begin
            $display("CHECK FAILED at %0t: %s expected %0d, got %0d",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    // Every bit low and none unknown
    task automatic check_cleared(input string name, input logic [7:0] actual);
        checks++;
        assert (actual === 8'h00) else begin
            $display("CHECK FAILED at %0t: %s expected %b, got %b",
                     $time, name, 8'h00, actual);
            errors++;
        end
    endtask

    task automatic clear_counters();
        lw_count   = 0;
        inc_count  = 0;
        dec_count  = 0;
        pas_cycles = 0;
        a1_cycles  = 0;
        sf_count   = 0;
        tenures    = 0;
        tenure_sum = 0;
    endtask

    // FIFO level is written on falling edges, so it is read on rising ones
    task automatic wait_level(input int target);
        int cycles;
        cycles = 0;
        while (fifo_level != target && cycles < TIMEOUT) begin
            @(posedge BCLK);
            cycles++;
        end
        if (fifo_level != target) begin
            $display("Timeout: FIFO level stuck at %0d, waiting for %0d", fifo_level, target);
            errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_bus_quiet();
        int cycles;
        int quiet;
        cycles = 0;
        quiet  = 0;
        while (quiet < QUIET && cycles < TIMEOUT) begin
            @(negedge BCLK);
            cycles++;
            if (strobe.breq || strobe.bgack) begin
                quiet = 0;
            end else begin
                quiet++;
            end
        end
        if (quiet < QUIET) begin
            $display("Timeout: bus master never gave the bus back");
            errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic run_vector(input int dir, input int port, input int level, input int flush,
                              input int exp_lw, input int exp_cycles, input int exp_sf);
        int err_before;
        int target;
        err_before = errors;
        target     = (dir != 0) ? 0 : DEPTH;
        test_num++;
        @(negedge BCLK);
        dma_dir    = dir[0];
        fifo_level = level;
        port_type  = port;
        // Let the new direction and level pass the synchronizers
        repeat (`CPU_SM_SYNC_STAGES + 2) @(negedge BCLK);
        @(posedge BCLK);
        clear_counters();
        @(negedge BCLK);
        flush_fifo = flush[0];
        dma_ena    = 1'b1;
        dreq_      = 1'b0;
        wait_level(target);
        if (!timed_out) begin
            wait_bus_quiet();
        end
        if (!timed_out) begin
            dma_ena    = 1'b0;
            dreq_      = 1'b1;
            flush_fifo = 1'b0;
            @(posedge BCLK);
            compare_count("incno", exp_lw, lw_count);
            compare_count("incfifo", (dir != 0) ? 0 : DEPTH - level, inc_count);
            compare_count("decfifo", (dir != 0) ? level : 0, dec_count);
            compare_count("pas cycles", exp_cycles, pas_cycles);
            compare_count("a1 cycles", (port == 1) ? exp_lw : 0, a1_cycles);
            compare_count("stopflush", exp_sf, sf_count);
            compare_count("tenure longword sum", exp_lw, tenure_sum);
            assert (tenures >= (exp_lw + LIMIT - 1) / LIMIT) else begin
                $display("Too few bus tenures at %0t: %0d for %0d longwords",
                         $time, tenures, exp_lw);
                errors++;
            end
        end
        $display("Test %0d dir=%0d port=%0d level=%0d flush=%0d: %0d lw, %0d cycles, %s",
                 test_num, dir, port, level, flush, lw_count, pas_cycles,
                 (errors == err_before) ? "ok" : "mismatch");
    endtask

    // Arbiter and bus slave answer on falling edges
    always @(negedge BCLK) begin
        if (!CCRESET_) begin
            bgrant_    = 1'b1;
            dsack_     = 2'b11;
            sterm_     = 1'b1;
            grant_wait = -1;
            slave_wait = -1;
            breq_seen  = 1'b0;
            grant_seen = 1'b0;
            bgack_q    = 1'b0;
        end else begin
            if (strobe.breq) begin
                breq_seen = 1'b1;
            end
            if (!bgrant_ && breq_seen) begin
                grant_seen = 1'b1;
            end
            if (strobe.bgack && !bgack_q) begin
                assert (breq_seen && grant_seen) else begin
                    $display("Bus taken at %0t without a request and a grant", $time);
                    errors++;
                end
                breq_seen  = 1'b0;
                grant_seen = 1'b0;
            end
            bgack_q = strobe.bgack;

            // Grant 1 to 3 cycles after the request
            if (!strobe.breq) begin
                bgrant_    = 1'b1;
                grant_wait = -1;
            end else if (bgrant_) begin
                if (grant_wait < 0) begin
                    rng        = xorshift32(rng);
                    grant_wait = 1 + int'(rng % 32'd3);
                end else if (grant_wait > 1) begin
                    grant_wait--;
                end else begin
                    bgrant_ = 1'b0;
                end
            end

            // Slave ends each strobe after 0 to 3 wait states
            if (!strobe.pas) begin
                dsack_     = 2'b11;
                sterm_     = 1'b1;
                slave_wait = -1;
            end else begin
                if (slave_wait < 0) begin
                    rng        = xorshift32(rng);
                    slave_wait = int'(rng % 32'd4);
                end else if (slave_wait > 0) begin
                    slave_wait--;
                end
                if (slave_wait == 0) begin
                    case (port_type)
                        0:       dsack_ = 2'b00;
                        1:       dsack_ = 2'b01;
                        default: sterm_ = 1'b0;
                    endcase
                end
            end
        end
    end

    // FIFO model and bus monitor
    always @(negedge BCLK) begin
        if (!CCRESET_) begin
            prev_pas   = 1'b0;
            prev_bgack = 1'b0;
        end else begin
            if (fifo_ctl.incfifo) begin
                assert (fifo_level < DEPTH) else begin
                    $display("FIFO overflow at %0t", $time);
                    errors++;
                end
                fifo_level++;
                inc_count++;
            end
            if (fifo_ctl.decfifo) begin
                assert (fifo_level > 0) else begin
                    $display("FIFO underflow at %0t", $time);
                    errors++;
                end
                fifo_level--;
                dec_count++;
            end
            if (fifo_ctl.incno) begin
                lw_count++;
                tenure_lw++;
            end
            if (fifo_ctl.stopflush) begin
                sf_count++;
            end
            if (strobe.pas && !prev_pas) begin
                pas_cycles++;
                if (strobe.a1) begin
                    a1_cycles++;
                end
            end
            if (strobe.bgack && !prev_bgack) begin
                tenure_lw = 0;
            end
            if (!strobe.bgack && prev_bgack) begin
                assert (tenure_lw <= LIMIT) else begin
                    $display("Burst limit broken at %0t: %0d longwords in one tenure",
                             $time, tenure_lw);
                    errors++;
                end
                tenures++;
                tenure_sum += tenure_lw;
            end
            assert (!(strobe.pas && !strobe.bgack)) else begin
                $display("Address strobe at %0t while the bus is not owned", $time);
                errors++;
            end
            assert (strobe.size1 == strobe.a1) else begin
                $display("size1 and a1 disagree at %0t", $time);
                errors++;
            end
            assert (fifo_ctl.dieh == fifo_ctl.incfifo && fifo_ctl.diel == fifo_ctl.incfifo)
            else begin
                $display("Data latch pulses out of step with incfifo at %0t", $time);
                errors++;
            end
            assert (fifo_ctl.f2cpuh == (strobe.pds && dma_dir) &&
                    fifo_ctl.f2cpul == (strobe.pds && dma_dir)) else begin
                $display("FIFO to CPU enables wrong during data phase at %0t", $time);
                errors++;
            end
            prev_pas   = strobe.pas;
            prev_bgack = strobe.bgack;
        end
    end

    initial begin
        int    fd;
        int    code;
        int    v_dir;
        int    v_port;
        int    v_level;
        int    v_flush;
        int    v_lw;
        int    v_cycles;
        int    v_sf;
        string line;
        CCRESET_   = 1'b0;
        dma_ena    = 1'b0;
        dreq_      = 1'b1;
        flush_fifo = 1'b0;
        dma_dir    = 1'b0;
        clear_counters();
        tenure_lw  = 0;

        // Outputs stay idle through reset and just after it
        repeat (5) begin
            @(negedge BCLK);
            check_cleared("strobe", strobe);
            check_cleared("fifo_ctl", fifo_ctl);
        end
        CCRESET_ = 1'b1;
        repeat (3) begin
            @(negedge BCLK);
            check_cleared("strobe", strobe);
            check_cleared("fifo_ctl", fifo_ctl);
        end
        $display("Test 0 reset: %s", (errors == 0) ? "ok" : "mismatch");

        fd = $fopen("test/cpu_sm_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vector file test/cpu_sm_vectors.txt");
            errors++;
        end else begin
            while (!timed_out && !$feof(fd)) begin
                line = "";
                code = $fgets(line, fd);
                // Comment and blank lines do not scan as seven numbers
                if (code != 0 && $sscanf(line, "%d %d %d %d %d %d %d", v_dir, v_port,
                                         v_level, v_flush, v_lw, v_cycles, v_sf) == 7) begin
                    run_vector(v_dir, v_port, v_level, v_flush, v_lw, v_cycles, v_sf);
                end
            end
            $fclose(fd);
        end

        $display("Summary: %0d tests, %0d checks, %0d errors", test_num, checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: cpu_sm.f
+incdir+hdl
hdl/cpu_bus_pkg.sv
hdl/dma_ctrl_pkg.sv
hdl/bus_term_decode.sv
hdl/xfer_request.sv
hdl/cpu_bus_fsm.sv
hdl/cpu_sm.sv
test/cpu_sm_tb.sv

// File: Bender.yml
package:
  name: cpu_sm

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/cpu_bus_pkg.sv
      - hdl/dma_ctrl_pkg.sv
      - hdl/bus_term_decode.sv
      - hdl/xfer_request.sv
      - hdl/cpu_bus_fsm.sv
      - hdl/cpu_sm.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - test/cpu_sm_tb.sv

// File: test/cpu_sm_vectors.txt
# dir port level flush longwords bus_cycles stopflush
# port: 0 = 32-bit DSACK pair, 1 = 16-bit DSACK1 only, 2 = STERM
0 0 0 0 8 8 0
0 2 5 0 3 3 0
1 1 6 0 6 12 0
1 1 3 1 3 6 1
1 0 8 1 8 8 1
0 1 2 1 6 12 0
1 2 4 0 4 4 0
0 0 7 0 1 1 0
0 2 1 0 7 7 0
1 0 5 1 5 5 1
